// ==== hdl/zynq_bridge_pkg.sv ====
`default_nettype none

package zynq_bridge_pkg;

   // basic widths
   typedef logic [31:0]  word_t;
   // the host window port drops the top two address bits
   typedef logic [29:0]  host_addr_t;
   typedef logic [31:0]  core_addr_t;
   typedef logic [31:0]  dram_addr_t;
   typedef logic [2:0]   reg_idx_t;
   typedef logic [6:0]   region_idx_t;
   typedef logic [127:0] region_map_t;

   // request from the host into the core window
   typedef struct packed {
      logic       valid;
      logic       write;
      host_addr_t addr;
      word_t      data;
   } host_req_t;

   // the same request after translation into core space
   typedef struct packed {
      logic       valid;
      logic       write;
      core_addr_t addr;
      word_t      data;
   } core_req_t;

   // host write strobe into the control registers
   typedef struct packed {
      logic     en;
      reg_idx_t idx;
      word_t    data;
   } csr_wr_t;

   // core DRAM starts here, so an XOR with it yields the offset
   localparam core_addr_t core_dram_base_lp = 32'h8000_0000;
   // 120 MiB upper bound on a DRAM offset
   localparam dram_addr_t dram_limit_lp = 32'h0780_0000;
   // regions are 8 MiB, indexed from address bits 29 down to 23
   localparam int region_msb_lp = 29;
   localparam int prof_words_lp = 4;

   localparam reg_idx_t reg_reset_lp = 3'd0;
   localparam reg_idx_t reg_alloc_lp = 3'd1;
   localparam reg_idx_t reg_base_lp  = 3'd2;
   localparam reg_idx_t reg_prof0_lp = 3'd3;

endpackage

`default_nettype wire

// ==== hdl/csr_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_regs
  (
   input  wire logic                      aclk_i,
   input  wire logic                      rst_n_i,
   input  wire zynq_bridge_pkg::csr_wr_t  csr_wr_i,
   output zynq_bridge_pkg::word_t         reset_reg_o,
   output zynq_bridge_pkg::word_t         alloc_reg_o,
   output zynq_bridge_pkg::word_t         base_reg_o,
   output logic                           core_rst_o
   );

   // host writes land at the next edge, unknown indices fall through
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         reset_reg_o <= '0;
         alloc_reg_o <= '0;
         base_reg_o  <= '0;
      end
      else if (csr_wr_i.en)
      begin
         case (csr_wr_i.idx)
            zynq_bridge_pkg::reg_reset_lp: reset_reg_o <= csr_wr_i.data;
            zynq_bridge_pkg::reg_alloc_lp: alloc_reg_o <= csr_wr_i.data;
            zynq_bridge_pkg::reg_base_lp:  base_reg_o  <= csr_wr_i.data;
            default:
            begin
            end
         endcase
      end
   end

   // the core is held in reset until the host sets bit 0 of register 0,
   // so a test run can be restarted without reloading the bitstream
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         core_rst_o <= 1'b1;
      end
      else
      begin
         core_rst_o <= ~reset_reg_o[0];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/host_addr_xlate.sv ====
`timescale 1ns/100ps
`default_nettype none

module host_addr_xlate
  (
   input  wire logic                        aclk_i,
   input  wire logic                        rst_n_i,
   input  wire zynq_bridge_pkg::host_req_t  host_req_i,
   output zynq_bridge_pkg::core_req_t       core_req_o
   );

   logic                        valid_q;
   logic                        write_q;
   zynq_bridge_pkg::core_addr_t addr_q;
   zynq_bridge_pkg::word_t      data_q;
   zynq_bridge_pkg::core_addr_t xlate_addr;

   // window 0x0000_0000 maps to core 0x8000_0000 (DRAM) and
   // window 0x2000_0000 maps to core 0x0000_0000 (local space)
   assign xlate_addr = {~host_req_i.addr[29], 3'b000, host_req_i.addr[27:0]};

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= host_req_i.valid;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (host_req_i.valid)
      begin
         write_q <= host_req_i.write;
         addr_q  <= xlate_addr;
         data_q  <= host_req_i.data;
      end
   end

   assign core_req_o = '{valid: valid_q, write: write_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// ==== hdl/dram_remap.sv ====
`timescale 1ns/100ps
`default_nettype none

module dram_remap
  (
   input  wire logic                         aclk_i,
   input  wire logic                         rst_n_i,
   input  wire logic                         dram_valid_i,
   input  wire zynq_bridge_pkg::core_addr_t  dram_addr_i,
   output logic                              dram_ready_o,
   input  wire zynq_bridge_pkg::word_t       base_i,
   output logic                              dram_valid_o,
   output zynq_bridge_pkg::dram_addr_t       dram_addr_o,
   input  wire logic                         dram_ready_i,
   output logic                              dram_range_err_o
   );

   logic                        out_valid_q;
   zynq_bridge_pkg::dram_addr_t out_addr_q;
   logic                        range_err_q;
   logic                        accept;
   zynq_bridge_pkg::dram_addr_t offset;

   // the stage takes a new beat when it is empty or its beat leaves this cycle
   assign dram_ready_o = ~out_valid_q | dram_ready_i;
   assign accept       = dram_valid_i & dram_ready_o;

   // XOR strips the core DRAM base, then the allocated PS buffer is added
   assign offset = dram_addr_i ^ zynq_bridge_pkg::core_dram_base_lp;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         out_valid_q <= 1'b0;
      end
      else if (accept)
      begin
         out_valid_q <= 1'b1;
      end
      else if (dram_ready_i)
      begin
         out_valid_q <= 1'b0;
      end
   end

   // base is sampled at acceptance, so a later write to it cannot move a held beat
   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         out_addr_q  <= offset + base_i;
         range_err_q <= (offset >= zynq_bridge_pkg::dram_limit_lp);
      end
   end

   assign dram_valid_o     = out_valid_q;
   assign dram_addr_o      = out_addr_q;
   assign dram_range_err_o = out_valid_q & range_err_q;

endmodule

`default_nettype wire

// ==== hdl/mem_profiler.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_profiler
  (
   input  wire logic                         aclk_i,
   input  wire logic                         rst_n_i,
   input  wire logic                         core_rst_i,
   input  wire logic                         hit_i,
   input  wire zynq_bridge_pkg::core_addr_t  hit_addr_i,
   output zynq_bridge_pkg::region_map_t      region_map_o
   );

   zynq_bridge_pkg::region_idx_t hit_region;

   // one bit per 8 MiB region shows how much memory a program touches
   assign hit_region =
      hit_addr_i[zynq_bridge_pkg::region_msb_lp -: $bits(zynq_bridge_pkg::region_idx_t)];

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         region_map_o <= '0;
      end
      else if (core_rst_i)
      begin
         // a fresh run starts with an empty map
         region_map_o <= '0;
      end
      else if (hit_i)
      begin
         region_map_o[hit_region] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/csr_readback.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_readback
  (
   input  wire logic                          aclk_i,
   input  wire logic                          rst_n_i,
   input  wire logic                          rd_en_i,
   input  wire zynq_bridge_pkg::reg_idx_t     rd_idx_i,
   input  wire zynq_bridge_pkg::word_t        reset_reg_i,
   input  wire zynq_bridge_pkg::word_t        alloc_reg_i,
   input  wire zynq_bridge_pkg::word_t        base_reg_i,
   input  wire zynq_bridge_pkg::region_map_t  region_map_i,
   output logic                               rd_valid_o,
   output zynq_bridge_pkg::word_t             rd_data_o
   );

   zynq_bridge_pkg::reg_idx_t prof_sel;
   zynq_bridge_pkg::word_t    rd_word;

   // profiler words follow the writable registers, lowest word first
   assign prof_sel = rd_idx_i - zynq_bridge_pkg::reg_prof0_lp;

   always_comb
   begin
      rd_word = '0;
      case (rd_idx_i)
         zynq_bridge_pkg::reg_reset_lp: rd_word = reset_reg_i;
         zynq_bridge_pkg::reg_alloc_lp: rd_word = alloc_reg_i;
         zynq_bridge_pkg::reg_base_lp:  rd_word = base_reg_i;
         default:
         begin
            // anything past the last profiler word reads as zero
            if (prof_sel < zynq_bridge_pkg::prof_words_lp)
            begin
               rd_word = region_map_i[prof_sel[1:0] * $bits(zynq_bridge_pkg::word_t) +:
                                      $bits(zynq_bridge_pkg::word_t)];
            end
         end
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_valid_o <= 1'b0;
      end
      else
      begin
         rd_valid_o <= rd_en_i;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (rd_en_i)
      begin
         rd_data_o <= rd_word;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/zynq_bridge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module zynq_bridge_top
  (
   input  wire logic                         aclk_i,
   input  wire logic                         rst_n_i,

   input  wire zynq_bridge_pkg::csr_wr_t     csr_wr_i,

   input  wire logic                         rd_en_i,
   input  wire zynq_bridge_pkg::reg_idx_t    rd_idx_i,
   output wire logic                         rd_valid_o,
   output wire zynq_bridge_pkg::word_t       rd_data_o,

   input  wire zynq_bridge_pkg::host_req_t   host_req_i,
   output wire zynq_bridge_pkg::core_req_t   core_req_o,

   input  wire logic                         dram_valid_i,
   input  wire zynq_bridge_pkg::core_addr_t  dram_addr_i,
   output wire logic                         dram_ready_o,
   output wire logic                         dram_valid_o,
   output wire zynq_bridge_pkg::dram_addr_t  dram_addr_o,
   input  wire logic                         dram_ready_i,
   output wire logic                         dram_range_err_o,

   output wire logic                         core_rst_o
   );

   zynq_bridge_pkg::word_t       reset_reg;
   zynq_bridge_pkg::word_t       alloc_reg;
   zynq_bridge_pkg::word_t       base_reg;
   zynq_bridge_pkg::region_map_t region_map;
   logic                         dram_hit;

   // host-side control registers
   csr_regs csr_regs_i
     (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .csr_wr_i    (csr_wr_i),
      .reset_reg_o (reset_reg),
      .alloc_reg_o (alloc_reg),
      .base_reg_o  (base_reg),
      .core_rst_o  (core_rst_o)
      );

   host_addr_xlate host_addr_xlate_i
     (
      .aclk_i     (aclk_i),
      .rst_n_i    (rst_n_i),
      .host_req_i (host_req_i),
      .core_req_o (core_req_o)
      );

   dram_remap dram_remap_i
     (
      .aclk_i           (aclk_i),
      .rst_n_i          (rst_n_i),
      .dram_valid_i     (dram_valid_i),
      .dram_addr_i      (dram_addr_i),
      .dram_ready_o     (dram_ready_o),
      .base_i           (base_reg),
      .dram_valid_o     (dram_valid_o),
      .dram_addr_o      (dram_addr_o),
      .dram_ready_i     (dram_ready_i),
      .dram_range_err_o (dram_range_err_o)
      );

   // the profiler counts a region on each beat the remap stage accepts
   assign dram_hit = dram_valid_i & dram_ready_o;

   mem_profiler mem_profiler_i
     (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .core_rst_i   (core_rst_o),
      .hit_i        (dram_hit),
      .hit_addr_i   (dram_addr_i),
      .region_map_o (region_map)
      );

   csr_readback csr_readback_i
     (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .rd_en_i      (rd_en_i),
      .rd_idx_i     (rd_idx_i),
      .reset_reg_i  (reset_reg),
      .alloc_reg_i  (alloc_reg),
      .base_reg_i   (base_reg),
      .region_map_i (region_map),
      .rd_valid_o   (rd_valid_o),
      .rd_data_o    (rd_data_o)
      );

endmodule

`default_nettype wire

// ==== test/zynq_bridge_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module zynq_bridge_assertions
  (
   input  wire logic                         aclk_i,
   input  wire logic                         rst_n_i,
   input  wire logic                         rd_en_i,
   input  wire logic                         rd_valid_o,
   input  wire logic                         dram_valid_o,
   input  wire logic                         dram_ready_i,
   input  wire zynq_bridge_pkg::dram_addr_t  dram_addr_o,
   input  wire logic                         core_rst_o,
   output logic [31:0]                       fail_count_o
   );

   int unsigned stable_fails = 0;
   int unsigned rd_fails     = 0;
   int unsigned rst_fails    = 0;

   assign fail_count_o = stable_fails + rd_fails + rst_fails;

   // a beat held under back-pressure keeps its address
   held_beat_stable: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      dram_valid_o && !dram_ready_i |=> $stable(dram_addr_o))
   else
   begin
      $error("held DRAM beat changed its address");
      stable_fails++;
   end

   rd_valid_follows_en: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rd_valid_o == $past(rd_en_i))
   else
   begin
      $error("rd_valid_o did not follow rd_en_i by one cycle");
      rd_fails++;
   end

   core_rst_in_reset: assert property (@(posedge aclk_i) !rst_n_i |-> core_rst_o)
   else
   begin
      $error("core_rst_o low while rst_n_i is asserted");
      rst_fails++;
   end

endmodule

bind zynq_bridge_top zynq_bridge_assertions zynq_bridge_assertions_i
  (
   .aclk_i       (aclk_i),
   .rst_n_i      (rst_n_i),
   .rd_en_i      (rd_en_i),
   .rd_valid_o   (rd_valid_o),
   .dram_valid_o (dram_valid_o),
   .dram_ready_i (dram_ready_i),
   .dram_addr_o  (dram_addr_o),
   .core_rst_o   (core_rst_o),
   .fail_count_o ()
   );

`default_nettype wire

// ==== test/zynq_bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module zynq_bridge_tb;

   localparam int          clk_half_lp  = 5;
   localparam int unsigned rand_seed_lp = 32'h8cd3;
   localparam int          reg_rows_lp  = 5;
   localparam int          host_rows_lp = 5;
   localparam int          dram_rows_lp = 12;
   // fixed reads plus a per-row allowance that covers the random DRAM ready
   localparam int watchdog_cycles_lp =
      150 + 8 * reg_rows_lp + 4 * host_rows_lp + 20 * dram_rows_lp;

   typedef struct packed {
      zynq_bridge_pkg::reg_idx_t idx;
      zynq_bridge_pkg::word_t    data;
      zynq_bridge_pkg::word_t    exp_data;
   } reg_row_t;

   typedef struct packed {
      logic                        write;
      zynq_bridge_pkg::host_addr_t addr;
      zynq_bridge_pkg::word_t      data;
      zynq_bridge_pkg::core_addr_t exp_addr;
   } host_row_t;

   typedef struct packed {
      zynq_bridge_pkg::core_addr_t addr;
      zynq_bridge_pkg::dram_addr_t exp_addr;
      logic                        exp_err;
   } dram_row_t;

   logic                          aclk_i = 1'b0;
   logic                          rst_n_i;
   zynq_bridge_pkg::csr_wr_t      csr_wr_i;
   logic                          rd_en_i;
   zynq_bridge_pkg::reg_idx_t     rd_idx_i;
   logic                          rd_valid_o;
   zynq_bridge_pkg::word_t        rd_data_o;
   zynq_bridge_pkg::host_req_t    host_req_i;
   zynq_bridge_pkg::core_req_t    core_req_o;
   logic                          dram_valid_i;
   zynq_bridge_pkg::core_addr_t   dram_addr_i;
   logic                          dram_ready_o;
   logic                          dram_valid_o;
   zynq_bridge_pkg::dram_addr_t   dram_addr_o;
   logic                          dram_ready_i;
   logic                          dram_range_err_o;
   logic                          core_rst_o;

   reg_row_t reg_tbl [reg_rows_lp] = '{
      '{idx: 3'd2, data: 32'h1000_0000, exp_data: 32'h1000_0000},
      '{idx: 3'd1, data: 32'h0000_0001, exp_data: 32'h0000_0001},
      // index 5 is a profiler word and the write must be dropped
      '{idx: 3'd5, data: 32'hdead_beef, exp_data: 32'h0000_0000},
      '{idx: 3'd7, data: 32'hffff_ffff, exp_data: 32'h0000_0000},
      '{idx: 3'd0, data: 32'h0000_0001, exp_data: 32'h0000_0001}
   };

   host_row_t host_tbl [host_rows_lp] = '{
      '{write: 1'b1, addr: 30'h0000_0000, data: 32'h0123_4567, exp_addr: 32'h8000_0000},
      '{write: 1'b0, addr: 30'h2000_0010, data: 32'h89ab_cdef, exp_addr: 32'h0000_0010},
      '{write: 1'b1, addr: 30'h1234_5678, data: 32'h5555_aaaa, exp_addr: 32'h8234_5678},
      '{write: 1'b0, addr: 30'h3fff_fffc, data: 32'hffff_0000, exp_addr: 32'h0fff_fffc},
      '{write: 1'b1, addr: 30'h2abc_def0, data: 32'h0000_ffff, exp_addr: 32'h0abc_def0}
   };

   // expected addresses use the base 0x1000_0000 written by the register table
   dram_row_t dram_tbl [dram_rows_lp] = '{
      '{addr: 32'h8000_0000, exp_addr: 32'h1000_0000, exp_err: 1'b0},
      '{addr: 32'h8080_0040, exp_addr: 32'h1080_0040, exp_err: 1'b0},
      '{addr: 32'h8100_0000, exp_addr: 32'h1100_0000, exp_err: 1'b0},
      '{addr: 32'h8320_0000, exp_addr: 32'h1320_0000, exp_err: 1'b0},
      '{addr: 32'h8770_0000, exp_addr: 32'h1770_0000, exp_err: 1'b0},
      '{addr: 32'h877f_fffc, exp_addr: 32'h177f_fffc, exp_err: 1'b0},
      '{addr: 32'h8780_0000, exp_addr: 32'h1780_0000, exp_err: 1'b1},
      '{addr: 32'h8fff_fffc, exp_addr: 32'h1fff_fffc, exp_err: 1'b1},
      '{addr: 32'h9400_0000, exp_addr: 32'h2400_0000, exp_err: 1'b1},
      '{addr: 32'ha000_0000, exp_addr: 32'h3000_0000, exp_err: 1'b1},
      '{addr: 32'hbf80_0000, exp_addr: 32'h4f80_0000, exp_err: 1'b1},
      '{addr: 32'h0000_1000, exp_addr: 32'h9000_1000, exp_err: 1'b1}
   };

   zynq_bridge_top zynq_bridge_top_i
     (
      .aclk_i           (aclk_i),
      .rst_n_i          (rst_n_i),
      .csr_wr_i         (csr_wr_i),
      .rd_en_i          (rd_en_i),
      .rd_idx_i         (rd_idx_i),
      .rd_valid_o       (rd_valid_o),
      .rd_data_o        (rd_data_o),
      .host_req_i       (host_req_i),
      .core_req_o       (core_req_o),
      .dram_valid_i     (dram_valid_i),
      .dram_addr_i      (dram_addr_i),
      .dram_ready_o     (dram_ready_o),
      .dram_valid_o     (dram_valid_o),
      .dram_addr_o      (dram_addr_o),
      .dram_ready_i     (dram_ready_i),
      .dram_range_err_o (dram_range_err_o),
      .core_rst_o       (core_rst_o)
      );

   always #clk_half_lp aclk_i = ~aclk_i;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
      if (got !== exp_val)
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp_val);
         $display("Finished with errors");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic write_reg(input zynq_bridge_pkg::reg_idx_t idx,
                            input zynq_bridge_pkg::word_t data);
      @(posedge aclk_i);
      csr_wr_i <= '{en: 1'b1, idx: idx, data: data};
      @(posedge aclk_i);
      csr_wr_i <= '0;
   endtask

   // the read answer is due exactly one cycle after the request
   task automatic read_and_compare(input zynq_bridge_pkg::reg_idx_t idx,
                                   input zynq_bridge_pkg::word_t exp_data);
      @(posedge aclk_i);
      rd_en_i  <= 1'b1;
      rd_idx_i <= idx;
      @(posedge aclk_i);
      rd_en_i <= 1'b0;
      @(negedge aclk_i);
      check_value("rd_valid_o", 32'(rd_valid_o), 32'd1);
      check_value($sformatf("rd_data_o[%0d]", idx), rd_data_o, exp_data);
   endtask

   task automatic send_host_row(input host_row_t row);
      @(posedge aclk_i);
      host_req_i <= '{valid: 1'b1, write: row.write, addr: row.addr, data: row.data};
      @(posedge aclk_i);
      host_req_i.valid <= 1'b0;
      @(negedge aclk_i);
      check_value("core_req_o.valid", 32'(core_req_o.valid), 32'd1);
      check_value("core_req_o.write", 32'(core_req_o.write), 32'(row.write));
      check_value("core_req_o.addr", core_req_o.addr, row.exp_addr);
      check_value("core_req_o.data", core_req_o.data, row.data);
   endtask

   task automatic stream_dram_table();
      int          in_idx;
      int          out_idx;
      int unsigned rnd;
      in_idx  = 0;
      out_idx = 0;
      @(posedge aclk_i);
      dram_valid_i <= 1'b1;
      dram_addr_i  <= dram_tbl[0].addr;
      while (out_idx < dram_rows_lp)
      begin
         @(negedge aclk_i);
         // the stage is ready when it is empty or its beat drains this cycle
         check_value("dram_ready_o", 32'(dram_ready_o),
                     32'(!dram_valid_o || dram_ready_i));
         // a beat leaves on the coming edge when valid and ready meet
         if (dram_valid_o && dram_ready_i)
         begin
            check_value("dram_addr_o", dram_addr_o, dram_tbl[out_idx].exp_addr);
            check_value("dram_range_err_o", 32'(dram_range_err_o),
                        32'(dram_tbl[out_idx].exp_err));
            out_idx++;
         end
         else if (!dram_valid_o)
         begin
            check_value("dram_range_err_o", 32'(dram_range_err_o), 32'd0);
         end
         if (dram_valid_i && dram_ready_o)
         begin
            in_idx++;
         end
         @(posedge aclk_i);
         rnd = $urandom;
         dram_ready_i <= rnd[0];
         dram_valid_i <= (in_idx < dram_rows_lp);
         if (in_idx < dram_rows_lp)
         begin
            dram_addr_i <= dram_tbl[in_idx].addr;
         end
      end
      @(negedge aclk_i);
      check_value("accepted beats", 32'(in_idx), 32'(dram_rows_lp));
      check_value("dram_valid_o", 32'(dram_valid_o), 32'd0);
   endtask

   initial
   begin
      zynq_bridge_pkg::word_t      reg_model [3];
      zynq_bridge_pkg::region_map_t region_model;
      void'($urandom(rand_seed_lp));
      rst_n_i      <= 1'b1;
      csr_wr_i     <= '0;
      rd_en_i      <= 1'b0;
      rd_idx_i     <= '0;
      host_req_i   <= '0;
      dram_valid_i <= 1'b0;
      dram_addr_i  <= '0;
      dram_ready_i <= 1'b0;
      #1 rst_n_i <= 1'b0;
      repeat (8) @(posedge aclk_i);
      rst_n_i <= 1'b1;

      @(negedge aclk_i);
      check_value("core_rst_o", 32'(core_rst_o), 32'd1);
      check_value("rd_valid_o", 32'(rd_valid_o), 32'd0);
      check_value("core_req_o.valid", 32'(core_req_o.valid), 32'd0);
      check_value("dram_valid_o", 32'(dram_valid_o), 32'd0);
      check_value("dram_range_err_o", 32'(dram_range_err_o), 32'd0);
      for (int i = 0; i < 7; i++)
      begin
         read_and_compare(3'(i), 32'd0);
      end

      // only indices 0 to 2 are writable
      reg_model = '{32'd0, 32'd0, 32'd0};
      for (int i = 0; i < reg_rows_lp; i++)
      begin
         write_reg(reg_tbl[i].idx, reg_tbl[i].data);
         if (reg_tbl[i].idx < 3'd3)
         begin
            reg_model[reg_tbl[i].idx] = reg_tbl[i].data;
         end
         read_and_compare(reg_tbl[i].idx, reg_tbl[i].exp_data);
      end
      for (int i = 0; i < 3; i++)
      begin
         read_and_compare(3'(i), reg_model[i]);
      end
      check_value("core_rst_o", 32'(core_rst_o), reg_model[0][0] ? 32'd0 : 32'd1);

      for (int i = 0; i < host_rows_lp; i++)
      begin
         send_host_row(host_tbl[i]);
      end
      @(posedge aclk_i);
      @(negedge aclk_i);
      check_value("core_req_o.valid", 32'(core_req_o.valid), 32'd0);

      // 8 MiB regions come from core address bits 29 down to 23
      region_model = '0;
      for (int i = 0; i < dram_rows_lp; i++)
      begin
         region_model[dram_tbl[i].addr[29:23]] = 1'b1;
      end
      stream_dram_table();
      for (int w = 0; w < 4; w++)
      begin
         read_and_compare(3'(w + 3), region_model[w * 32 +: 32]);
      end

      // restarting the core clears the profiler
      write_reg(3'd0, 32'd0);
      @(posedge aclk_i);
      @(negedge aclk_i);
      check_value("core_rst_o", 32'(core_rst_o), 32'd1);
      write_reg(3'd0, 32'd1);
      @(posedge aclk_i);
      @(negedge aclk_i);
      check_value("core_rst_o", 32'(core_rst_o), 32'd0);
      for (int w = 0; w < 4; w++)
      begin
         read_and_compare(3'(w + 3), 32'd0);
      end

      if (zynq_bridge_top_i.zynq_bridge_assertions_i.fail_count_o != 0)
      begin
         $display("%0d assertion failures during the run",
                  zynq_bridge_top_i.zynq_bridge_assertions_i.fail_count_o);
         $display("Finished with errors");
         $fatal(1, "assertions failed");
      end
      else
      begin
         $display("Finished with no errors");
         $finish;
      end
   end

   // a failed assertion in the bound checker ends the run at once
   always @(negedge aclk_i)
   begin
      if (zynq_bridge_top_i.zynq_bridge_assertions_i.fail_count_o != 0)
      begin
         $display("an assertion in the bound checker failed");
         $display("Finished with errors");
         $fatal(1, "assertions failed");
      end
   end

   initial
   begin
      repeat (watchdog_cycles_lp) @(posedge aclk_i);
      $display("timeout: the run did not finish within %0d cycles", watchdog_cycles_lp);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== zynq_bridge.f ====
hdl/zynq_bridge_pkg.sv
hdl/csr_regs.sv
hdl/host_addr_xlate.sv
hdl/dram_remap.sv
hdl/mem_profiler.sv
hdl/csr_readback.sv
hdl/zynq_bridge_top.sv
test/zynq_bridge_assertions.sv
test/zynq_bridge_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := zynq_bridge_tb
FILELIST   := zynq_bridge.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
RUN_FLAGS  := +verilator+error+limit+100
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
